// File: files.f
logic/conv_pkg.sv
logic/conv_ctrl_regs.sv
logic/line_buffer.sv
logic/window_mac.sv
logic/conv_sequencer.sv
logic/conv_top.sv
bench/conv_tb.sv

// File: run.sh
#!/bin/sh
# Build the convolution testbench with Verilator, run it and check the log for the pass line
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module conv_tb -f files.f -o conv_sim > build.log 2>&1 \
    && ./obj_dir/conv_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^Result: PASSED$" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// File: bench/conv_tb.sv
// Testbench for the 3x3 convolution engine, table driven frames checked against a model
`timescale 1ns/1ns

module conv_tb;

    typedef struct packed {
        int width;
        int height;
        bit start;          // Start bit during the frame
        bit stall;          // Random back-pressure and input gaps
        bit clear;          // Clear-all after the frame
        int seed;           // Offset added to the generator seed
    } test_row_t;

    localparam int num_tests = 6;

    logic              axi_clk;
    logic              axi_reset_n;
    logic              s_axis_valid;
    logic [31:0]       s_axis_data;
    logic              s_axis_ready;
    logic              m_axis_valid;
    conv_pkg::result_t m_axis_data;
    logic              m_axis_last;
    logic              m_axis_ready;
    logic [7:0]        s_axi_awaddr;
    logic              s_axi_awvalid;
    logic              s_axi_awready;
    logic [31:0]       s_axi_wdata;
    logic              s_axi_wvalid;
    logic              s_axi_wready;
    logic              s_axi_bvalid;
    logic              s_axi_bready;
    logic [7:0]        s_axi_araddr;
    logic              s_axi_arvalid;
    logic              s_axi_arready;
    logic [31:0]       s_axi_rdata;
    logic              s_axi_rvalid;
    logic              s_axi_rready;
    logic              s_axi_rlast;

    test_row_t         tests [num_tests];
    logic [31:0]       rng;                 // LCG state
    logic [7:0]        pixels [$];          // Current frame, row-major
    logic signed [7:0] coef_vals [9];
    int                expected [$];
    int                errors;
    int                failed_tests;

    conv_top conv_top_inst (.*);

    initial begin
        axi_clk = 1'b0;
        forever #20 axi_clk = ~axi_clk;     // 40 ns period
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng;
    endfunction

    function automatic bit coin_flip();
        logic [31:0] r;
        r = lcg_next();
        return r[20];                       // Upper bits, low ones cycle too fast
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("ERROR: %s", what);
            errors++;
        end
    endtask

    // One-beat write, bready is tied high
    task automatic bus_write(input int addr, input logic [31:0] data);
        @(negedge axi_clk);
        s_axi_awaddr  = 8'(addr);
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        while (!(s_axi_awready && s_axi_wready)) @(negedge axi_clk);
        @(negedge axi_clk);                 // Taken on the edge just passed
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid) @(negedge axi_clk);
        @(negedge axi_clk);
    endtask

    task automatic bus_read(input int addr, output logic [31:0] data);
        @(negedge axi_clk);
        s_axi_araddr  = 8'(addr);
        s_axi_arvalid = 1'b1;
        while (!s_axi_arready) @(negedge axi_clk);
        @(negedge axi_clk);
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) @(negedge axi_clk);
        data = s_axi_rdata;
        check_true(s_axi_rlast, "rlast low on a single-beat read");
        @(negedge axi_clk);
    endtask

    task automatic read_check(input int addr, input logic [31:0] exp, input string name);
        logic [31:0] word;
        bus_read(addr, word);
        check_word(name, word, exp);
    endtask

    // Reference: taps in row-major window order, bottom-right corner at (x, y)
    function automatic int model_result(int x, int y, int w);
        int sum;
        sum = 0;
        for (int k = 0; k < 9; k++)
            sum += int'(coef_vals[k]) * int'(pixels[(y - 2 + k / 3) * w + x - 2 + k % 3]);
        return sum;
    endfunction

    // --------------------
    // Stream tasks
    // --------------------
    task automatic run_frame(input test_row_t t);
        int pix_idx;
        int res_idx;
        int n_res;
        int n_pix;
        expected.delete();
        for (int y = 2; y < t.height; y++)
            for (int x = 2; x < t.width; x++)
                expected.push_back(model_result(x, y, t.width));
        n_res   = expected.size();
        n_pix   = t.width * t.height;
        pix_idx = 0;
        res_idx = 0;
        while (res_idx < n_res) begin
            @(negedge axi_clk);
            m_axis_ready = t.stall ? coin_flip() : 1'b1;
            s_axis_valid = (pix_idx < n_pix) && (!t.stall || coin_flip() || coin_flip());
            s_axis_data  = (pix_idx < n_pix) ? {8'h5a, 16'(pix_idx), pixels[pix_idx]} : '0;
            #1;                                         // Sample once inputs settle
            if (s_axis_valid && s_axis_ready) pix_idx++;
            if (m_axis_valid && m_axis_ready) begin
                check_word($sformatf("m_axis_data[%0d]", res_idx), m_axis_data,
                           expected[res_idx]);
                check_word($sformatf("m_axis_last[%0d]", res_idx), 32'(m_axis_last),
                           32'(res_idx == n_res - 1));
                res_idx++;
            end
        end
        @(negedge axi_clk);
        s_axis_valid = 1'b0;
        m_axis_ready = 1'b1;
        repeat (10) begin                               // Nothing trails the last beat
            @(negedge axi_clk);
            #1;
            check_true(!m_axis_valid, "result appeared after the end of the frame");
        end
    endtask

    task automatic run_start_low();
        repeat (50) begin
            @(negedge axi_clk);
            s_axis_valid = 1'b1;
            s_axis_data  = 32'h0000_00ff;
            m_axis_ready = 1'b1;
            #1;
            check_true(!s_axis_ready, "s_axis_ready high while start is low");
            check_true(!m_axis_valid, "m_axis_valid high while start is low");
        end
        @(negedge axi_clk);
        s_axis_valid = 1'b0;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        test_row_t   t;
        logic [31:0] word;
        int          errors_before;
        axi_reset_n   = 1'b0;
        s_axis_valid  = 1'b0;
        s_axis_data   = '0;
        m_axis_ready  = 1'b1;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        errors        = 0;
        failed_tests  = 0;
        //            width height start stall clear seed
        tests[0] = '{5,    4,     1'b1, 1'b0, 1'b0, 7};
        tests[1] = '{5,    4,     1'b1, 1'b1, 1'b0, 7};    // Same pixels, stalled
        tests[2] = '{8,    6,     1'b1, 1'b1, 1'b1, 21};
        tests[3] = '{4,    4,     1'b0, 1'b0, 1'b0, 3};    // Start held low
        tests[4] = '{3,    3,     1'b1, 1'b0, 1'b1, 44};   // Single window
        tests[5] = '{12,   7,     1'b1, 1'b1, 1'b0, 90};
        repeat (8) @(posedge axi_clk);
        @(negedge axi_clk);
        axi_reset_n = 1'b1;

        for (int i = 0; i < num_tests; i++) begin
            t             = tests[i];
            errors_before = errors;
            rng           = 32'd99332 + 32'(t.seed);
            pixels.delete();
            for (int k = 0; k < 9; k++)
                coef_vals[k] = 8'(lcg_next() >> 16);
            for (int p = 0; p < t.width * t.height; p++)
                pixels.push_back(8'(lcg_next() >> 16));

            bus_write(conv_pkg::reg_ctrl_off, 32'd0);
            bus_write(conv_pkg::reg_width_off, 32'(t.width));
            bus_write(conv_pkg::reg_height_off, 32'(t.height));
            for (int k = 0; k < 9; k++)
                bus_write(conv_pkg::reg_filter_off + 4 * k, {24'h0, coef_vals[k]});
            read_check(conv_pkg::reg_width_off, 32'(t.width), "width");
            read_check(conv_pkg::reg_height_off, 32'(t.height), "height");
            for (int k = 0; k < 9; k++)
                read_check(conv_pkg::reg_filter_off + 4 * k, {24'h0, coef_vals[k]},
                           $sformatf("coef[%0d]", k));
            bus_read(conv_pkg::reg_id_off, word);
            check_word("id[11:0]", 32'(word[11:0]), 32'h130);  // One channel, side 3, key 0
            read_check(24, 32'd0, "offset 24");         // Stride slot, unmapped

            if (t.start) begin
                bus_write(conv_pkg::reg_ctrl_off, 32'd1);
                run_frame(t);
                read_check(conv_pkg::reg_result_off, expected[$], "last result");
            end else begin
                run_start_low();
            end

            if (t.clear) begin
                bus_write(conv_pkg::reg_clear_off, 32'd1);
                read_check(conv_pkg::reg_ctrl_off, 32'd0, "ctrl after clear");
                read_check(conv_pkg::reg_width_off, 32'd0, "width after clear");
                read_check(conv_pkg::reg_height_off, 32'd0, "height after clear");
                for (int k = 0; k < 9; k++)
                    read_check(conv_pkg::reg_filter_off + 4 * k, 32'd0,
                               $sformatf("coef[%0d] after clear", k));
            end
            bus_write(conv_pkg::reg_ctrl_off, 32'd0);   // Stop so counters restart

            if (errors != errors_before) failed_tests++;
            $display("test %0d: %0dx%0d start=%0d stall=%0d clear=%0d -> %s", i, t.width,
                     t.height, t.start, t.stall, t.clear,
                     (errors == errors_before) ? "ok" : "errors");
        end

        $display("Tests: %0d run, %0d failed, %0d check errors", num_tests, failed_tests,
                 errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        int limit;
        limit = 0;
        @(posedge axi_reset_n);
        for (int i = 0; i < num_tests; i++)
            limit += 8 * tests[i].width * tests[i].height + 300;   // Budget per test
        repeat (limit) @(posedge axi_clk);
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: logic/conv_top.sv
// Top level of the 3x3 convolution engine with its control port and streams
`timescale 1ns/1ns

module conv_top (
    input  logic                                axi_clk,
    input  logic                                axi_reset_n,
    input  logic                                s_axis_valid,
    input  logic [conv_pkg::bus_width-1:0]      s_axis_data,
    output logic                                s_axis_ready,
    output logic                                m_axis_valid,
    output conv_pkg::result_t                   m_axis_data,
    output logic                                m_axis_last,
    input  logic                                m_axis_ready,
    input  logic [conv_pkg::addr_width-1:0]     s_axi_awaddr,
    input  logic                                s_axi_awvalid,
    output logic                                s_axi_awready,
    input  logic [conv_pkg::bus_width-1:0]      s_axi_wdata,
    input  logic                                s_axi_wvalid,
    output logic                                s_axi_wready,
    output logic                                s_axi_bvalid,
    input  logic                                s_axi_bready,
    input  logic [conv_pkg::addr_width-1:0]     s_axi_araddr,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    output logic [conv_pkg::bus_width-1:0]      s_axi_rdata,
    output logic                                s_axi_rvalid,
    input  logic                                s_axi_rready,
    output logic                                s_axi_rlast
);

    // --------------------
    // Internal wiring
    // --------------------
    logic                               start;
    logic [conv_pkg::col_width-1:0]     image_width;
    logic [conv_pkg::col_width-1:0]     image_height;
    conv_pkg::coef_set_t                coefs;
    logic                               result_capture;     // Result leaving on m_axis
    conv_pkg::result_t                  result_value;
    logic                               pixel_accept;
    conv_pkg::pixel_t                   pixel_in;
    logic [conv_pkg::col_width-1:0]     col;
    logic                               advance;
    logic                               tap_valid;
    logic                               tap_last;
    conv_pkg::window_t                  window;
    logic                               mac_valid;
    logic                               mac_last;
    conv_pkg::result_t                  mac_sum;

    conv_ctrl_regs conv_ctrl_regs_inst (
        .axi_clk, .axi_reset_n,
        .s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bvalid, .s_axi_bready,
        .s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rdata, .s_axi_rvalid, .s_axi_rready, .s_axi_rlast,
        .result_capture, .result_value,
        .start, .image_width, .image_height, .coefs
    );

    conv_sequencer conv_sequencer_inst (
        .axi_clk, .axi_reset_n, .start, .image_width, .image_height,
        .s_axis_valid, .s_axis_data, .m_axis_ready,
        .mac_valid, .mac_last, .mac_sum,
        .s_axis_ready, .pixel_accept, .pixel_in, .col, .advance,
        .tap_valid, .tap_last,
        .m_axis_valid, .m_axis_data, .m_axis_last,
        .result_capture, .result_value
    );

    line_buffer line_buffer_inst (
        .axi_clk, .axi_reset_n, .pixel_accept, .pixel_in, .col, .window
    );

    window_mac window_mac_inst (
        .axi_clk, .axi_reset_n, .advance, .tap_valid, .tap_last,
        .window, .coefs, .mac_valid, .mac_last, .mac_sum
    );

endmodule

// File: logic/conv_sequencer.sv
// Pixel counters, window tagging, stall control and output stream register
`timescale 1ns/1ns

module conv_sequencer (
    input  logic                                axi_clk,
    input  logic                                axi_reset_n,
    input  logic                                start,
    input  logic [conv_pkg::col_width-1:0]      image_width,
    input  logic [conv_pkg::col_width-1:0]      image_height,
    input  logic                                s_axis_valid,
    input  logic [conv_pkg::bus_width-1:0]      s_axis_data,
    input  logic                                m_axis_ready,
    input  logic                                mac_valid,
    input  logic                                mac_last,
    input  conv_pkg::result_t                   mac_sum,
    output logic                                s_axis_ready,
    output logic                                pixel_accept,
    output conv_pkg::pixel_t                    pixel_in,
    output logic [conv_pkg::col_width-1:0]      col,
    output logic                                advance,
    output logic                                tap_valid,
    output logic                                tap_last,
    output logic                                m_axis_valid,
    output conv_pkg::result_t                   m_axis_data,
    output logic                                m_axis_last,
    output logic                                result_capture,
    output conv_pkg::result_t                   result_value
);

    logic [conv_pkg::col_width-1:0] row;

    wire end_of_row   = (col == image_width - 1'b1);
    wire end_of_frame = end_of_row && (row == image_height - 1'b1);
    wire window_full  = (col >= 2) && (row >= 2);      // Bottom-right corner of a window

    assign advance        = !m_axis_valid || m_axis_ready;  // Whole pipe freezes on stall
    assign s_axis_ready   = start && advance;
    assign pixel_accept   = s_axis_valid && s_axis_ready;
    assign pixel_in       = s_axis_data[conv_pkg::pixel_width-1:0];   // Low byte only
    assign result_capture = m_axis_valid && m_axis_ready;
    assign result_value   = m_axis_data;

    // --------------------
    // Position counters
    // --------------------
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n || !start) begin
            col <= '0;
            row <= '0;
        end else if (pixel_accept) begin
            col <= end_of_row ? '0 : col + 1'b1;
            if (end_of_frame)
                row <= '0;                          // Next frame starts over
            else if (end_of_row)
                row <= row + 1'b1;
        end
    end

    // Tags line up with the window registered on the same edge
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            tap_valid <= 1'b0;
            tap_last  <= 1'b0;
        end else if (advance) begin
            tap_valid <= pixel_accept && window_full;
            tap_last  <= pixel_accept && end_of_frame;
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            m_axis_valid <= 1'b0;
            m_axis_last  <= 1'b0;
        end else if (advance) begin
            m_axis_valid <= mac_valid;
            m_axis_last  <= mac_last;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (advance) m_axis_data <= mac_sum;
    end

    // Stalled output holds its beat
    assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        (m_axis_valid && !m_axis_ready) |=> (m_axis_valid && $stable(m_axis_data)));

endmodule

// File: logic/window_mac.sv
// Two-stage pipelined multiply and sum over the 3x3 window
`timescale 1ns/1ns

module window_mac (
    input  logic                    axi_clk,
    input  logic                    axi_reset_n,
    input  logic                    advance,
    input  logic                    tap_valid,
    input  logic                    tap_last,
    input  conv_pkg::window_t       window,
    input  conv_pkg::coef_set_t     coefs,
    output logic                    mac_valid,
    output logic                    mac_last,
    output conv_pkg::result_t       mac_sum
);

    localparam int prod_width = conv_pkg::pixel_width + conv_pkg::coef_width + 1;

    logic signed [prod_width-1:0]   prod [conv_pkg::kernel_taps];
    logic                           prod_valid;
    logic                           prod_last;
    conv_pkg::result_t              sum_comb;

    // --------------------
    // Stage one
    // --------------------
    always_ff @(posedge axi_clk) begin
        if (advance) begin
            for (int k = 0; k < conv_pkg::kernel_taps; k++)
                prod[k] <= $signed({1'b0, window[k]}) * $signed(coefs[k]); // Pixel is unsigned
        end
    end

    // Adder tree feeding stage two
    always_comb begin
        sum_comb = '0;
        for (int k = 0; k < conv_pkg::kernel_taps; k++)
            sum_comb = sum_comb + prod[k];
    end

    // --------------------
    // Stage two
    // --------------------
    always_ff @(posedge axi_clk) begin
        if (advance) mac_sum <= sum_comb;
    end

    // Tags ride alongside the data
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
            mac_valid  <= 1'b0;
            mac_last   <= 1'b0;
        end else if (advance) begin
            prod_valid <= tap_valid;
            prod_last  <= tap_last;
            mac_valid  <= prod_valid;
            mac_last   <= prod_last;
        end
    end

endmodule

// File: logic/line_buffer.sv
// Two row memories and the 3x3 window shift registers
`timescale 1ns/1ns

module line_buffer (
    input  logic                            axi_clk,
    input  logic                            axi_reset_n,
    input  logic                            pixel_accept,
    input  conv_pkg::pixel_t                pixel_in,
    input  logic [conv_pkg::col_width-1:0]  col,
    output conv_pkg::window_t               window
);

    // --------------------
    // Row memories
    // --------------------
    conv_pkg::pixel_t row1_mem [conv_pkg::max_image_width];    // One row back
    conv_pkg::pixel_t row2_mem [conv_pkg::max_image_width];    // Two rows back

    conv_pkg::pixel_t mid_pix;      // Same column, previous row
    conv_pkg::pixel_t top_pix;      // Same column, two rows up

    assign mid_pix = row1_mem[col];
    assign top_pix = row2_mem[col];

    always_ff @(posedge axi_clk) begin
        if (pixel_accept) begin
            row1_mem[col] <= pixel_in;
            row2_mem[col] <= mid_pix;   // Older row cascades down
        end
    end

    // --------------------
    // Window shift
    // --------------------
    always_ff @(posedge axi_clk) begin
        if (pixel_accept) begin
            for (int r = 0; r < conv_pkg::kernel_size; r++) begin
                window[3*r]   <= window[3*r+1];     // Columns age to the left
                window[3*r+1] <= window[3*r+2];
            end
            window[2] <= top_pix;                   // Newest column, oldest row first
            window[5] <= mid_pix;
            window[8] <= pixel_in;
        end
    end

    // Columns are written in order, each accept steps to the next one or wraps
    assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        pixel_accept |=> ((col == '0) || (col == $past(col) + 1'b1)));

endmodule

// File: logic/conv_ctrl_regs.sv
// AXI-lite style control slave holding start, image size, coefficients and last result
`timescale 1ns/1ns

module conv_ctrl_regs (
    input  logic                                axi_clk,
    input  logic                                axi_reset_n,
    input  logic [conv_pkg::addr_width-1:0]     s_axi_awaddr,
    input  logic                                s_axi_awvalid,
    output logic                                s_axi_awready,
    input  logic [conv_pkg::bus_width-1:0]      s_axi_wdata,
    input  logic                                s_axi_wvalid,
    output logic                                s_axi_wready,
    output logic                                s_axi_bvalid,
    input  logic                                s_axi_bready,
    input  logic [conv_pkg::addr_width-1:0]     s_axi_araddr,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    output logic [conv_pkg::bus_width-1:0]      s_axi_rdata,
    output logic                                s_axi_rvalid,
    input  logic                                s_axi_rready,
    output logic                                s_axi_rlast,
    input  logic                                result_capture,
    input  conv_pkg::result_t                   result_value,
    output logic                                start,
    output logic [conv_pkg::col_width-1:0]      image_width,
    output logic [conv_pkg::col_width-1:0]      image_height,
    output conv_pkg::coef_set_t                 coefs
);

    conv_pkg::bus_state_t               state;
    logic                               clear_pend;     // Clear bit, acts one cycle later
    conv_pkg::result_t                  last_result;
    logic [conv_pkg::bus_width-1:0]     rd_word;

    wire wr_take = (state == conv_pkg::bus_idle) && s_axi_awvalid && s_axi_wvalid;
    wire rd_take = (state == conv_pkg::bus_idle) && !wr_take && s_axi_arvalid; // Write wins

    // --------------------
    // Read decode
    // --------------------
    always_comb begin
        rd_word = '0;                                   // Unmapped offsets read zero
        case (s_axi_araddr)
            conv_pkg::reg_ctrl_off:   rd_word[0] = start;
            conv_pkg::reg_clear_off:  rd_word[0] = clear_pend;
            conv_pkg::reg_id_off: begin
                rd_word[3:0]  = 4'(conv_pkg::conv_layer_key);
                rd_word[7:4]  = 4'(conv_pkg::kernel_size);
                rd_word[11:8] = 4'(conv_pkg::channel_count);
            end
            conv_pkg::reg_result_off: rd_word = last_result;
            conv_pkg::reg_width_off:  rd_word[conv_pkg::col_width-1:0] = image_width;
            conv_pkg::reg_height_off: rd_word[conv_pkg::col_width-1:0] = image_height;
            default: begin
                for (int k = 0; k < conv_pkg::kernel_taps; k++) begin
                    if (s_axi_araddr == conv_pkg::addr_width'(conv_pkg::reg_filter_off + 4 * k))
                        rd_word[conv_pkg::coef_width-1:0] = coefs[k];
                end
            end
        endcase
    end

    // --------------------
    // Handshake and register file
    // --------------------
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            state         <= conv_pkg::bus_idle;
            s_axi_awready <= 1'b1;
            s_axi_wready  <= 1'b1;
            s_axi_arready <= 1'b1;
            s_axi_bvalid  <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rlast   <= 1'b0;
            start         <= 1'b0;
            clear_pend    <= 1'b0;
            image_width   <= '0;
            image_height  <= '0;
            coefs         <= '0;
            last_result   <= '0;
        end else begin
            if (result_capture) last_result <= result_value;   // Track the latest output
            case (state)
                conv_pkg::bus_idle: begin
                    if (wr_take || rd_take) begin
                        s_axi_awready <= 1'b0;  // Single beat, hold off the next one
                        s_axi_wready  <= 1'b0;
                        s_axi_arready <= 1'b0;
                    end
                    if (wr_take) begin
                        state        <= conv_pkg::bus_write_resp;
                        s_axi_bvalid <= 1'b1;
                        case (s_axi_awaddr)
                            conv_pkg::reg_ctrl_off:   start        <= s_axi_wdata[0];
                            conv_pkg::reg_clear_off:  clear_pend   <= s_axi_wdata[0];
                            conv_pkg::reg_width_off:  image_width  <= s_axi_wdata[5:0];
                            conv_pkg::reg_height_off: image_height <= s_axi_wdata[5:0];
                            default: begin
                                for (int k = 0; k < conv_pkg::kernel_taps; k++) begin
                                    if (s_axi_awaddr == conv_pkg::addr_width'(
                                            conv_pkg::reg_filter_off + 4 * k))
                                        coefs[k] <= s_axi_wdata[conv_pkg::coef_width-1:0];
                                end
                            end
                        endcase
                    end else if (rd_take) begin
                        state        <= conv_pkg::bus_read_resp;
                        s_axi_rvalid <= 1'b1;
                        s_axi_rlast  <= 1'b1;   // Every read is one beat
                    end
                end
                conv_pkg::bus_write_resp: if (s_axi_bready) begin
                    state         <= conv_pkg::bus_idle;
                    s_axi_bvalid  <= 1'b0;
                    s_axi_awready <= 1'b1;
                    s_axi_wready  <= 1'b1;
                    s_axi_arready <= 1'b1;
                end
                conv_pkg::bus_read_resp: if (s_axi_rready) begin
                    state         <= conv_pkg::bus_idle;
                    s_axi_rvalid  <= 1'b0;
                    s_axi_rlast   <= 1'b0;
                    s_axi_awready <= 1'b1;
                    s_axi_wready  <= 1'b1;
                    s_axi_arready <= 1'b1;
                end
                default: state <= conv_pkg::bus_idle;
            endcase
            // Clear-all wipes every writable register, the clear bit too
            if (clear_pend) begin
                start        <= 1'b0;
                clear_pend   <= 1'b0;
                image_width  <= '0;
                image_height <= '0;
                coefs        <= '0;
            end
        end
    end

    always_ff @(posedge axi_clk) begin
        if (rd_take) s_axi_rdata <= rd_word;            // Held until rready
    end

    // Write response never overlaps a new address phase
    assert property (@(posedge axi_clk) disable iff (!axi_reset_n)
        !(s_axi_bvalid && s_axi_awready));

endmodule

// File: logic/conv_pkg.sv
// Shared sizes, register map and types of the 3x3 convolution engine
package conv_pkg;

    // --------------------
    // Sizes
    // --------------------
    localparam int kernel_size     = 3;              // Window side
    localparam int kernel_taps     = 9;              // Window taps
    localparam int bus_width       = 32;             // Data and register word
    localparam int addr_width      = 8;              // Control port address
    localparam int max_image_width = 64;             // Row memory depth
    localparam int col_width       = 6;              // Row and column counters
    localparam int pixel_width     = 8;
    localparam int coef_width      = 8;

    // Identity fields
    localparam int conv_layer_key  = 0;
    localparam int channel_count   = 1;

    // --------------------
    // Register byte offsets
    // --------------------
    localparam int reg_ctrl_off    = 0;              // Bit 0 is start
    localparam int reg_clear_off   = 4;              // Bit 0 clears all writable regs
    localparam int reg_id_off      = 8;              // Read only
    localparam int reg_result_off  = 12;             // Most recent result sent out
    localparam int reg_width_off   = 16;
    localparam int reg_height_off  = 20;
    localparam int reg_filter_off  = 28;             // Tap k at plus 4*k

    // --------------------
    // Types
    // --------------------
    typedef logic        [pixel_width-1:0] pixel_t;
    typedef logic signed [coef_width-1:0]  coef_t;
    typedef logic signed [bus_width-1:0]   result_t;

    // Tap k sits at row k/3 and column k%3, row 0 and column 0 oldest
    typedef pixel_t [kernel_taps-1:0] window_t;
    typedef coef_t  [kernel_taps-1:0] coef_set_t;

    // Control port sequencing
    typedef enum logic [1:0] {
        bus_idle,
        bus_write_resp,
        bus_read_resp
    } bus_state_t;

endpackage
